//--- periph_pkg.sv
// peripheral cluster package: bus widths, register offsets, bus and ramp command types
`default_nettype none

package periph_pkg;

    parameter int addr_width = 16; // bus address
    parameter int data_width = 8;  // bus data and every register

    // register offsets inside one pwm peripheral
    parameter logic [addr_width-1:0] off_period = 16'd0;
    parameter logic [addr_width-1:0] off_duty   = 16'd1;

    // one bus cycle, 26 bits
    typedef struct packed {
        logic                  enable;   // active this clock
        logic                  write_en;
        logic [addr_width-1:0] addr;
        logic [data_width-1:0] wdata;
    } bus_req_t;

    // ramp request from the outside, 48 bits
    typedef struct packed {
        logic [addr_width-1:0] addr;        // target duty register
        logic [data_width-1:0] start_duty;
        logic [data_width-1:0] end_duty;
        logic [15:0]           step_cycles; // clocks between writes
    } ramp_cmd_t;

endpackage

`default_nettype wire

//--- bus_arbiter.sv
// fixed-priority arbiter putting the host port or the ramp engine onto the shared bus
`timescale 1ns/10ps
`default_nettype none

module bus_arbiter (
    input  wire                   clk,
    input  wire                   reset,
    input  periph_pkg::bus_req_t  host_req,
    input  periph_pkg::bus_req_t  ramp_req,
    output logic                  ramp_grant,
    output periph_pkg::bus_req_t  bus
);

    // host always wins, ramp only gets idle host cycles
    always_comb
    begin
        if (host_req.enable)
        begin
            bus        = host_req;
            ramp_grant = 1'b0;
        end
        else
        begin
            bus        = ramp_req;
            ramp_grant = ramp_req.enable;
        end
    end

    // a stalled ramp write must be presented again unchanged
    a_ramp_hold : assert property (
        @(posedge clk) disable iff (!reset)
        (ramp_req.enable && !ramp_grant) |=> (ramp_req == $past(ramp_req))
    );

endmodule

`default_nettype wire

//--- pwm_core.sv
// pwm core with period counter, duty compare and restart when the settings change
`timescale 1ns/10ps
`default_nettype none

module pwm_core #(
    parameter int width = periph_pkg::data_width
) (
    input  wire              clk,
    input  wire              reset,
    input  wire [width-1:0]  period,
    input  wire [width-1:0]  duty,
    output logic             out
);

    logic [width-1:0]   count;
    logic [2*width-1:0] prev_settings; // period and duty seen last clock
    logic               change;

    assign change = {period, duty} != prev_settings;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            prev_settings <= '0;
        end
        else
        begin
            prev_settings <= {period, duty};
        end
    end

    // counts 0..period, so one period is period+1 clocks
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= '0;
        end
        else if (change || count >= period)
        begin
            count <= '0; // restart from the top, output high again
        end
        else
        begin
            count <= count + 1'b1;
        end
    end

    // duty 0 is flat low, duty past the period is flat high
    always_comb
    begin
        if (duty == '0)
        begin
            out = 1'b0;
        end
        else if (duty > period)
        begin
            out = 1'b1;
        end
        else
        begin
            out = count < duty;
        end
    end

    // a new setting starts its period high unless duty is zero
    a_restart_high : assert property (
        @(posedge clk) disable iff (!reset)
        change |=> (duty == '0 || out)
    );

endmodule

`default_nettype wire

//--- pwm_periph.sv
// pwm peripheral: period and duty registers on the shared bus driving one pwm core
`timescale 1ns/10ps
`default_nettype none

module pwm_periph #(
    parameter logic [periph_pkg::addr_width-1:0] base_addr = 16'hff1a
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  periph_pkg::bus_req_t                bus,
    output logic [periph_pkg::data_width-1:0]   rdata,
    output logic                                out
);

    localparam logic [periph_pkg::addr_width-1:0] period_addr = base_addr + periph_pkg::off_period;
    localparam logic [periph_pkg::addr_width-1:0] duty_addr   = base_addr + periph_pkg::off_duty;

    logic [periph_pkg::data_width-1:0] period;
    logic [periph_pkg::data_width-1:0] duty;
    logic                              hit_period;
    logic                              hit_duty;

    // address decode
    assign hit_period = bus.enable && (bus.addr == period_addr);
    assign hit_duty   = bus.enable && (bus.addr == duty_addr);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            period <= '0;
            duty   <= '0;
        end
        else if (bus.write_en)
        begin
            if (hit_period)
            begin
                period <= bus.wdata;
            end
            if (hit_duty)
            begin
                duty <= bus.wdata;
            end
        end
    end

    // readback is zero unless addressed, so the top can OR the slaves
    always_comb
    begin
        if (hit_period)
        begin
            rdata = period;
        end
        else if (hit_duty)
        begin
            rdata = duty;
        end
        else
        begin
            rdata = '0;
        end
    end

    pwm_core #(
        .width (periph_pkg::data_width)
    ) core0 (
        .clk    (clk),
        .reset  (reset),
        .period (period),
        .duty   (duty),
        .out    (out)
    );

endmodule

`default_nettype wire

//--- pwm_ramp.sv
// ramp engine stepping a duty register from a start to an end value with timed writes
`timescale 1ns/10ps
`default_nettype none

module pwm_ramp (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    start,
    input  periph_pkg::ramp_cmd_t  cmd,
    input  wire                    grant,
    output periph_pkg::bus_req_t   req,
    output logic                   busy
);

    periph_pkg::ramp_cmd_t             cmd_q;   // latched on start
    logic [periph_pkg::data_width-1:0] cur;     // value being written
    logic [15:0]                       timer;
    logic                              pending; // write waiting for grant

    always_comb
    begin
        req.enable   = pending;
        req.write_en = 1'b1;
        req.addr     = cmd_q.addr;
        req.wdata    = cur;
    end

    // latch the command, step cur toward end_duty after each grant
    always_ff @(posedge clk)
    begin
        if (start && !busy)
        begin
            cmd_q <= cmd;
            cur   <= cmd.start_duty;
        end
        else if (pending && grant && cur != cmd_q.end_duty)
        begin
            if (cmd_q.end_duty > cur)
            begin
                cur <= cur + 1'b1; // ramp up
            end
            else
            begin
                cur <= cur - 1'b1; // ramp down
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            busy    <= 1'b0;
            pending <= 1'b0;
            timer   <= '0;
        end
        else if (!busy)
        begin
            if (start)
            begin
                busy    <= 1'b1;
                pending <= 1'b1; // start value goes out first
            end
        end
        else if (pending)
        begin
            if (grant)
            begin
                pending <= 1'b0;
                timer   <= cmd_q.step_cycles; // wait counts from the grant
                if (cur == cmd_q.end_duty)
                begin
                    busy <= 1'b0;
                end
            end
        end
        else if (timer <= 16'd1)
        begin
            pending <= 1'b1;
        end
        else
        begin
            timer <= timer - 1'b1;
        end
    end

    a_req_busy : assert property (
        @(posedge clk) disable iff (!reset)
        req.enable |-> busy
    );

endmodule

`default_nettype wire

//--- pwm_subsys.sv
// pwm subsystem top joining host port, ramp engine, arbiter and two pwm peripherals
`timescale 1ns/10ps
`default_nettype none

module pwm_subsys #(
    parameter logic [periph_pkg::addr_width-1:0] base_addr0 = 16'hff1a,
    parameter logic [periph_pkg::addr_width-1:0] base_addr1 = 16'hff1c
) (
    input  wire                                 clk,
    input  wire                                 reset,
    input  periph_pkg::bus_req_t                host_req,
    output logic [periph_pkg::data_width-1:0]   rdata,
    input  wire                                 ramp_start,
    input  periph_pkg::ramp_cmd_t               ramp_cmd,
    output logic                                ramp_busy,
    output logic [1:0]                          pwm_out
);

    periph_pkg::bus_req_t              ramp_req;
    periph_pkg::bus_req_t              bus;
    logic                              ramp_grant;
    logic [periph_pkg::data_width-1:0] rdata0;
    logic [periph_pkg::data_width-1:0] rdata1;

    assign rdata = rdata0 | rdata1; // unaddressed slaves return zero

    bus_arbiter arb0 (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .ramp_req   (ramp_req),
        .ramp_grant (ramp_grant),
        .bus        (bus)
    );

    pwm_ramp ramp0 (
        .clk   (clk),
        .reset (reset),
        .start (ramp_start),
        .cmd   (ramp_cmd),
        .grant (ramp_grant),
        .req   (ramp_req),
        .busy  (ramp_busy)
    );

    pwm_periph #(.base_addr(base_addr0)) pwm0 (
        .clk   (clk),
        .reset (reset),
        .bus   (bus),
        .rdata (rdata0),
        .out   (pwm_out[0])
    );

    pwm_periph #(.base_addr(base_addr1)) pwm1 (
        .clk   (clk),
        .reset (reset),
        .bus   (bus),
        .rdata (rdata1),
        .out   (pwm_out[1])
    );

endmodule

`default_nettype wire

//--- pwm_subsys_tb.sv
// testbench for the pwm subsystem covering register access, duty table, ramps and bus stall
`timescale 1ns/10ps
`default_nettype none

module pwm_subsys_tb;

    localparam int n_tests = 8;
    localparam int k = 3;                        // periods per count window
    localparam int win_max = k * 32;             // random periods stay below 32
    localparam int ramp_max = 10 * (5 + 2) + 30; // ten steps of 5 plus a stall burst
    localparam int timeout_cycles = 2 * (n_tests * (2 * win_max + 6) + 3 * ramp_max + 100);

    logic                  clk;
    logic                  reset;
    periph_pkg::bus_req_t  host_req;
    logic [7:0]            rdata;
    logic                  ramp_start;
    periph_pkg::ramp_cmd_t ramp_cmd;
    logic                  ramp_busy;
    logic [1:0]            pwm_out;
    integer                seed = 32'h0b6d_0018;
    string                 tname [n_tests];
    int                    tchan [n_tests];
    int                    tperiod [n_tests];
    int                    tduty [n_tests];
    int                    texp [n_tests]; // high cycles over k periods

    pwm_subsys dut0 (
        .clk        (clk),
        .reset      (reset),
        .host_req   (host_req),
        .rdata      (rdata),
        .ramp_start (ramp_start),
        .ramp_cmd   (ramp_cmd),
        .ramp_busy  (ramp_busy),
        .pwm_out    (pwm_out)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // watchdog
    initial
    begin
        #(timeout_cycles * 40);
        $display("timeout: simulation ran past %0d clock cycles", timeout_cycles);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic add_entry(input int i, input string name, input int chan, period, duty,
                             expected);
        tname[i]   = name;
        tchan[i]   = chan;
        tperiod[i] = period;
        tduty[i]   = duty;
        texp[i]    = expected;
    endtask

    // one host strobe, reads compare rdata mid cycle
    task automatic bus_access(input string name, input logic write, input logic [15:0] addr,
                              input logic [7:0] data);
        host_req.enable   = 1'b1;
        host_req.write_en = write;
        host_req.addr     = addr;
        host_req.wdata    = data;
        #10;
        if (!write)
            check_value(name, data, rdata);
        @(negedge clk);
        host_req = '0;
    endtask

    task automatic count_high(input int chan, input int cycles, output logic [31:0] high);
        high = 0;
        repeat (cycles)
        begin
            high += pwm_out[chan]; // sampled at the falling edge
            @(negedge clk);
        end
    endtask

    // ramps always target channel 1 duty
    task automatic start_ramp(input string name, input logic [7:0] first, last_duty);
        ramp_cmd.addr        = 16'hff1d;
        ramp_cmd.start_duty  = first;
        ramp_cmd.end_duty    = last_duty;
        ramp_cmd.step_cycles = 16'd5;
        ramp_start = 1'b1;
        @(negedge clk);
        ramp_start = 1'b0;
        check_value({name, "_busy"}, 1, ramp_busy);
    endtask

    task automatic finish_ramp(input string name, input logic [7:0] last_duty);
        while (ramp_busy)
            @(negedge clk);
        bus_access({name, "_end"}, 1'b0, 16'hff1d, last_duty);
    endtask

    initial
    begin
        int          i, j, c, p, d;
        int          last [2];
        logic [31:0] high;
        reset      = 1'b0;
        host_req   = '0;
        ramp_start = 1'b0;
        ramp_cmd   = '0;
        repeat (2) @(negedge clk);
        reset = 1'b1;

        for (i = 0; i < 4; i++)
            bus_access("reset_regs", 1'b0, 16'hff1a + i, 8'h00);
        repeat (20)
        begin
            check_value("reset_pwm_low", 0, pwm_out);
            @(negedge clk);
        end

        for (i = 0; i < 4; i++)
            bus_access("reg_write", 1'b1, 16'hff1a + i, 8'h5a + 8'h31 * i);
        for (i = 0; i < 4; i++)
            bus_access("reg_readback", 1'b0, 16'hff1a + i, 8'h5a + 8'h31 * i);
        bus_access("unmapped_hi", 1'b0, 16'hff1e, 8'h00);
        bus_access("unmapped_lo", 1'b0, 16'hff19, 8'h00);

        add_entry(0, "ch0_mid", 0, 9, 3, 9);
        add_entry(1, "ch1_half", 1, 15, 8, 24);
        add_entry(2, "ch0_duty_zero", 0, 7, 0, 0);
        add_entry(3, "ch1_duty_over", 1, 5, 9, 18);
        add_entry(4, "ch0_duty_eq_period", 0, 6, 6, 18);
        add_entry(5, "ch1_period_zero", 1, 0, 1, 3);
        for (i = 6; i < n_tests; i++)
        begin
            p = $random(seed) & 31;
            d = ($random(seed) & 31) % (p + 3); // sometimes above the period
            c = $random(seed) & 1;
            add_entry(i, $sformatf("random_%0d", i), c, p, d, (d > p) ? k * (p + 1) : k * d);
        end

        last[0] = -1;
        last[1] = -1;
        for (i = 0; i < n_tests; i++)
        begin
            c = tchan[i];
            bus_access(tname[i], 1'b1, 16'hff1a + 2 * c, tperiod[i]);
            bus_access(tname[i], 1'b1, 16'hff1b + 2 * c, tduty[i]);
            repeat (4) @(negedge clk);
            count_high(c, k * (tperiod[i] + 1), high);
            check_value(tname[i], texp[i], high);
            last[c] = i;
            j = last[1 - c];
            if (j >= 0) // other channel keeps running on its own setting
            begin
                count_high(1 - c, k * (tperiod[j] + 1), high);
                check_value({tname[j], "_other"}, texp[j], high);
            end
        end

        start_ramp("ramp_up", 8'd2, 8'd9);
        finish_ramp("ramp_up", 8'd9);
        start_ramp("ramp_down", 8'd9, 8'd3);
        finish_ramp("ramp_down", 8'd3);

        // host strobes every cycle, ramp write has to wait
        bus_access("stall_setup", 1'b1, 16'hff1a, 8'd20);
        bus_access("stall_setup", 1'b1, 16'hff1b, 8'd7);
        start_ramp("ramp_stall", 8'd3, 8'd7);
        for (i = 0; i < 30; i++)
            bus_access("stall_ch0", 1'b0, 16'hff1a + i % 2, (i % 2) ? 8'd7 : 8'd20);
        check_value("stall_busy", 1, ramp_busy);
        finish_ramp("ramp_stall", 8'd7);

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

//--- pwm_subsys.f
periph_pkg.sv
bus_arbiter.sv
pwm_core.sv
pwm_periph.sv
pwm_ramp.sv
pwm_subsys.sv
pwm_subsys_tb.sv
